/* ula_pkg.sv */
package ula_pkg;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [9:0]  hcount_t;      // Clock within line, 0..799
    typedef logic [9:0]  vcount_t;      // Line within frame, 0..524
    typedef logic [12:0] vram_addr_t;   // Video RAM byte address
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  colour_idx_t;  // {bright, grb}
    typedef logic [11:0] rgb_t;         // {r, g, b} at 4 bits each

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 640x480 raster and Spectrum window
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam hcount_t H_TOTAL      = 10'd800;
    localparam vcount_t V_TOTAL      = 10'd525;
    localparam hcount_t H_SYNC       = 10'd96;
    localparam vcount_t V_SYNC       = 10'd2;
    localparam hcount_t H_DISP_START = 10'd144;
    localparam hcount_t H_DISP_END   = 10'd784;
    localparam vcount_t V_DISP_START = 10'd35;
    localparam vcount_t V_DISP_END   = 10'd515;
    localparam hcount_t H_SCR_START  = 10'd208;   // 512 wide after doubling
    localparam hcount_t H_SCR_END    = 10'd720;
    localparam vcount_t V_SCR_START  = 10'd83;    // 384 lines after doubling
    localparam vcount_t V_SCR_END    = 10'd467;
    localparam vcount_t IRQ_LINE     = 10'd35;
    localparam hcount_t IRQ_WIDTH    = 10'd100;

    // Memory map
    localparam vram_addr_t  VRAM_BYTES  = 13'd6912;
    localparam vram_addr_t  ATTR_BASE   = 13'd6144;   // Attributes follow 6K of bitmap
    localparam logic [13:0] BORDER_ADDR = 14'h2000;

    // Bit 0 blue, bit 1 red, bit 2 green; bright lifts level D to F
    function automatic rgb_t palette_rgb(colour_idx_t idx);
        logic [3:0] lvl;
        lvl = idx[3] ? 4'hF : 4'hD;
        return {idx[1] ? lvl : 4'h0, idx[2] ? lvl : 4'h0, idx[0] ? lvl : 4'h0};
    endfunction

endpackage

/* raster_if.sv */
`timescale 1ns/1ns

// Raster position and window flags, one driver and several readers
interface raster_if import ula_pkg::*; ();

    hcount_t hc;            // Horizontal counter
    vcount_t vc;            // Vertical counter
    logic    flash_phase;   // Toggles every 16 frames
    logic    disp_en;       // Inside 640x480
    logic    screen_en;     // Inside 512x384

    modport source (
        output hc, vc, flash_phase, disp_en, screen_en
    );

    modport sink (
        input hc, vc, flash_phase, disp_en, screen_en
    );

endinterface

/* vga_timing.sv */
`timescale 1ns/1ns

module vga_timing import ula_pkg::*; (
    input  logic     clk_pix,
    input  logic     rst_n,
    raster_if.source raster,
    output logic     hsync,
    output logic     vsync,
    output logic     irq_n          // Vertical retrace interrupt, active low
);

    hcount_t    hc;
    hcount_t    hc_nxt;
    vcount_t    vc;
    vcount_t    vc_nxt;
    logic [4:0] frame;              // Frame counter for flash
    logic [4:0] frame_nxt;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Counter next state
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        hc_nxt    = hc + 10'd1;
        vc_nxt    = vc;
        frame_nxt = frame;
        if (hc == H_TOTAL - 10'd1) begin          // End of line
            hc_nxt = '0;
            if (vc == V_TOTAL - 10'd1) begin      // End of frame
                vc_nxt    = '0;
                frame_nxt = frame + 5'd1;
            end else begin
                vc_nxt = vc + 10'd1;
            end
        end
    end

    // Sync outputs follow the next counter values so they line up with hc/vc
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            hc    <= '0;
            vc    <= '0;
            frame <= '0;
            hsync <= 1'b0;
            vsync <= 1'b0;
            irq_n <= 1'b1;
        end else begin
            hc    <= hc_nxt;
            vc    <= vc_nxt;
            frame <= frame_nxt;
            hsync <= (hc_nxt >= H_SYNC);
            vsync <= (vc_nxt >= V_SYNC);
            irq_n <= !(vc_nxt == IRQ_LINE && hc_nxt < IRQ_WIDTH);
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Window flags
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign raster.hc          = hc;
    assign raster.vc          = vc;
    assign raster.flash_phase = frame[4];       // 16 frames on, 16 off
    assign raster.disp_en     = (hc >= H_DISP_START) && (hc < H_DISP_END) &&
                                (vc >= V_DISP_START) && (vc < V_DISP_END);
    assign raster.screen_en   = (hc >= H_SCR_START) && (hc < H_SCR_END) &&
                                (vc >= V_SCR_START) && (vc < V_SCR_END);

endmodule

/* screen_fetch.sv */
`timescale 1ns/1ns

module screen_fetch import ula_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst_n,
    raster_if.sink     raster,
    output vram_addr_t vram_vid_addr,
    input  byte_t      vid_data,        // One clock after the address
    output byte_t      cell_bits,       // Working bitmap byte
    output byte_t      cell_attr        // Working attribute byte
);

    hcount_t    col_ofs;                // Offset into screen, one cell ahead
    vcount_t    row_ofs;
    logic [4:0] col;                    // Character column 0..31
    logic [7:0] row;                    // Spectrum pixel line 0..191
    vram_addr_t bmp_addr;
    vram_addr_t attr_addr;
    byte_t      bits_pre;               // Prefetch registers
    byte_t      attr_pre;

    // 16 clocks per byte, lines doubled vertically
    assign col_ofs = raster.hc - H_SCR_START + 10'd16;
    assign row_ofs = raster.vc - V_SCR_START;
    assign col     = col_ofs[8:4];
    assign row     = row_ofs[8:1];

    // Bitmap swizzle: third, pixel line in char, char row, column
    assign bmp_addr  = {row[7:6], row[2:0], row[5:3], col};
    assign attr_addr = ATTR_BASE + vram_addr_t'({row[7:3], col});

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per-cell fetch sequence on hc[3:0]
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_pix) begin
        case (raster.hc[3:0])
            4'd10: vram_vid_addr <= bmp_addr;       // Bitmap for next cell
            4'd12: begin
                bits_pre      <= vid_data;
                vram_vid_addr <= attr_addr;
            end
            4'd14: attr_pre <= vid_data;
            default: ;
        endcase
    end

    // Hand over to the working registers at the last clock of the cell
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            cell_bits <= '0;
            cell_attr <= '0;
        end else if (raster.hc[3:0] == 4'd15) begin
            cell_bits <= bits_pre;
            cell_attr <= attr_pre;
        end
    end

endmodule

/* pixel_render.sv */
`timescale 1ns/1ns

module pixel_render import ula_pkg::*; (
    raster_if.sink raster,
    input  byte_t       cell_bits,
    input  byte_t       cell_attr,
    input  logic  [2:0] border,
    output logic  [3:0] vga_r,
    output logic  [3:0] vga_g,
    output logic  [3:0] vga_b
);

    logic        pix_bit;       // Current pixel, ink when set
    logic        flash;
    logic        bright;
    logic        invert;
    logic  [2:0] ink;
    logic  [2:0] paper;
    colour_idx_t cindex;
    rgb_t        rgb;

    // Each Spectrum pixel spans two clocks, MSB first
    assign pix_bit = cell_bits[3'd7 - raster.hc[3:1]];

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Attribute decode
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign flash  = cell_attr[7];
    assign bright = cell_attr[6];
    assign invert = flash & raster.flash_phase;     // Swap ink and paper
    assign ink    = invert ? cell_attr[5:3] : cell_attr[2:0];
    assign paper  = invert ? cell_attr[2:0] : cell_attr[5:3];

    always_comb begin
        if (raster.screen_en) begin
            cindex = pix_bit ? {bright, ink} : {bright, paper};
        end else begin
            cindex = {1'b0, border};                // Border is never bright
        end
    end

    assign rgb = palette_rgb(cindex);

    // Blank outside the visible area
    assign vga_r = raster.disp_en ? rgb[11:8] : 4'h0;
    assign vga_g = raster.disp_en ? rgb[7:4]  : 4'h0;
    assign vga_b = raster.disp_en ? rgb[3:0]  : 4'h0;

endmodule

/* vram.sv */
`timescale 1ns/1ns

module vram import ula_pkg::*; (
    input  logic       clk_pix,
    // CPU port, read and write
    input  vram_addr_t cpu_addr,
    input  logic       cpu_we,
    input  byte_t      cpu_wdata,
    output byte_t      cpu_rdata,
    // Video port, read only
    input  vram_addr_t vid_addr,
    output byte_t      vid_data
);

    byte_t mem [0:VRAM_BYTES-1];    // 6K bitmap then 768 attributes

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU port
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_pix) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_wdata;
        end
        cpu_rdata <= mem[cpu_addr];     // Old data on a same-cycle write
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Video port
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_pix) begin
        vid_data <= mem[vid_addr];      // Sees the old byte on a collision
    end

endmodule

/* apb_ula_port.sv */
`timescale 1ns/1ns

module apb_ula_port import ula_pkg::*; (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  logic [13:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  byte_t       pwdata,
    output byte_t       prdata,
    output logic        pready,
    output logic        pslverr,
    output vram_addr_t  cpu_addr,
    output logic        cpu_we,
    output byte_t       cpu_wdata,
    input  byte_t       cpu_rdata,
    output logic  [2:0] border
);

    logic sel_ram;
    logic sel_brd;
    logic addr_err;
    logic setup;            // First cycle of a transfer
    logic access_done;      // Access cycle that completes

    // Address decode
    assign sel_ram  = (paddr < {1'b0, VRAM_BYTES});
    assign sel_brd  = (paddr == BORDER_ADDR);
    assign addr_err = !sel_ram && !sel_brd;

    assign setup       = psel && !penable;
    assign access_done = psel && penable && pready;

    // RAM is addressed straight from the bus, data ready after the setup cycle
    assign cpu_addr  = paddr[12:0];
    assign cpu_wdata = pwdata;
    assign cpu_we    = access_done && pwrite && sel_ram;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake and border register
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            border  <= 3'd0;
        end else begin
            pready  <= 1'b0;                        // One-cycle pulse
            pslverr <= 1'b0;
            if (setup && pwrite) begin              // Writes finish in first access
                pready  <= 1'b1;
                pslverr <= addr_err;
            end else if (psel && penable && !pready && !pwrite) begin
                pready  <= 1'b1;                    // Read wait state over
                pslverr <= addr_err;
            end
            if (access_done && pwrite && sel_brd) begin
                border <= pwdata[2:0];
            end
        end
    end

    // Read data captured during the wait state
    always_ff @(posedge clk_pix) begin
        if (psel && penable && !pready && !pwrite) begin
            prdata <= sel_ram ? cpu_rdata :
                      sel_brd ? {5'd0, border} : 8'h00;
        end
    end

endmodule

/* ula_video_top.sv */
`timescale 1ns/1ns

module ula_video_top import ula_pkg::*; (
    input  logic        clk_pix,
    input  logic        rst_n,
    // APB slave
    input  logic [13:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic  [7:0] pwdata,
    output logic  [7:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // VGA
    output logic  [3:0] vga_r,
    output logic  [3:0] vga_g,
    output logic  [3:0] vga_b,
    output logic        hsync,
    output logic        vsync,
    output logic        irq_n
);

    vram_addr_t  cpu_addr;
    logic        cpu_we;
    byte_t       cpu_wdata;
    byte_t       cpu_rdata;
    vram_addr_t  vram_vid_addr;
    byte_t       vid_data;
    byte_t       cell_bits;
    byte_t       cell_attr;
    logic  [2:0] border;

    raster_if raster ();

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Video path
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    vga_timing vga_timing_inst (
        .clk_pix (clk_pix), .rst_n (rst_n), .raster (raster.source),
        .hsync   (hsync),   .vsync (vsync), .irq_n  (irq_n)
    );

    screen_fetch screen_fetch_inst (
        .clk_pix       (clk_pix),       .rst_n    (rst_n),
        .raster        (raster.sink),   .vram_vid_addr (vram_vid_addr),
        .vid_data      (vid_data),      .cell_bits (cell_bits),
        .cell_attr     (cell_attr)
    );

    pixel_render pixel_render_inst (
        .raster    (raster.sink), .cell_bits (cell_bits), .cell_attr (cell_attr),
        .border    (border),      .vga_r     (vga_r),     .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory and CPU side
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    vram vram_inst (
        .clk_pix   (clk_pix),   .cpu_addr  (cpu_addr),      .cpu_we   (cpu_we),
        .cpu_wdata (cpu_wdata), .cpu_rdata (cpu_rdata),
        .vid_addr  (vram_vid_addr), .vid_data (vid_data)
    );

    apb_ula_port apb_ula_port_inst (
        .clk_pix (clk_pix), .rst_n   (rst_n),   .paddr     (paddr),
        .psel    (psel),    .penable (penable), .pwrite    (pwrite),
        .pwdata  (pwdata),  .prdata  (prdata),  .pready    (pready),
        .pslverr (pslverr), .cpu_addr (cpu_addr), .cpu_we  (cpu_we),
        .cpu_wdata (cpu_wdata), .cpu_rdata (cpu_rdata), .border (border)
    );

endmodule

/* ula_video_assertions.sv */
`timescale 1ns/1ns

module ula_video_assertions import ula_pkg::*; (
    input logic        clk_pix,
    input logic        rst_n,
    input logic [13:0] paddr,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic        pready,
    input logic        hsync
);

    hcount_t low_cnt;       // Consecutive low hsync cycles so far

    always_ff @(posedge clk_pix) begin
        if (!rst_n || hsync) begin
            low_cnt <= '0;
        end else begin
            low_cnt <= low_cnt + 10'd1;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB handshake and sync width
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    apb_hold : assert property (@(posedge clk_pix) disable iff (!rst_n)
        (penable && !pready) |-> ($stable(paddr) && $stable(pwrite)))
        else $error("paddr or pwrite changed during an APB wait state");

    ready_in_access : assert property (@(posedge clk_pix) disable iff (!rst_n)
        pready |-> (psel && penable))
        else $error("pready high outside an APB access phase");

    // Rise of hsync closes a low pulse of exactly H_SYNC clocks
    hsync_width : assert property (@(posedge clk_pix) disable iff (!rst_n)
        $rose(hsync) |-> (low_cnt == H_SYNC))
        else $error("hsync low pulse is not H_SYNC clocks wide");

endmodule

bind ula_video_top ula_video_assertions ula_video_assertions_inst (
    .clk_pix (clk_pix), .rst_n  (rst_n),  .paddr  (paddr),  .psel  (psel),
    .penable (penable), .pwrite (pwrite), .pready (pready), .hsync (hsync)
);

/* tb_ula_video.sv */
`timescale 1ns/1ns

module tb_ula_video import ula_pkg::*; ();

    localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int CYCLE_LIMIT  = 40 * FRAME_CYCLES;    // Last check sits in frame 17

    logic        clk_pix;
    logic        rst_n;
    logic [13:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic  [7:0] pwdata;
    logic  [7:0] prdata;
    logic        pready;
    logic        pslverr;
    logic  [3:0] vga_r;
    logic  [3:0] vga_g;
    logic  [3:0] vga_b;
    logic        hsync;
    logic        vsync;
    logic        irq_n;

    byte_t      vram_m [0:VRAM_BYTES-1];    // Mirror of video RAM
    logic [2:0] border_m;
    hcount_t    m_hc;                       // Model raster position
    vcount_t    m_vc;
    logic [4:0] m_frame;
    rgb_t       row1 [0:511];               // Screen row seen in frame 1
    integer     seed = 32'h1df5_a9a5;
    int         errors = 0;
    int         err_mark = 0;
    int         tests_ok = 0;
    int         tests_bad = 0;
    int         cycles = 0;

    ula_video_top ula_video_top_inst (
        .clk_pix (clk_pix), .rst_n   (rst_n),   .paddr   (paddr),   .psel  (psel),
        .penable (penable), .pwrite  (pwrite),  .pwdata  (pwdata),  .prdata (prdata),
        .pready  (pready),  .pslverr (pslverr), .vga_r   (vga_r),   .vga_g (vga_g),
        .vga_b   (vga_b),   .hsync   (hsync),   .vsync   (vsync),   .irq_n (irq_n)
    );

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;     // 25 MHz pixel clock
    end

    // Raster model starting at 0,0 of frame 0 on the first clock after reset
    always @(posedge clk_pix) begin
        if (!rst_n) begin
            m_hc    <= '0;
            m_vc    <= '0;
            m_frame <= '0;
        end else if (m_hc == H_TOTAL - 10'd1) begin
            m_hc <= '0;
            if (m_vc == V_TOTAL - 10'd1) begin
                m_vc    <= '0;
                m_frame <= m_frame + 5'd1;
            end else begin
                m_vc <= m_vc + 10'd1;
            end
        end else begin
            m_hc <= m_hc + 10'd1;
        end
    end

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and bookkeeping
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // Colour at one raster position from the Spectrum screen layout
    function automatic rgb_t model_pixel(hcount_t hc, vcount_t vc, logic phase);
        hcount_t    xo;
        vcount_t    yo;
        logic [7:0] px;                     // Spectrum pixel column
        logic [7:0] row;                    // Spectrum pixel line
        byte_t      bits;
        byte_t      attr;
        logic [2:0] ink;
        logic [2:0] paper;
        logic       pix;
        if (!(hc >= H_DISP_START && hc < H_DISP_END && vc >= V_DISP_START && vc < V_DISP_END))
            return 12'h000;                 // Blanking
        if (!(hc >= H_SCR_START && hc < H_SCR_END && vc >= V_SCR_START && vc < V_SCR_END))
            return palette_rgb({1'b0, border_m});
        xo    = hc - H_SCR_START;
        yo    = vc - V_SCR_START;
        px    = xo[8:1];                    // Pixels and lines are doubled
        row   = yo[8:1];
        bits  = vram_m[{row[7:6], row[2:0], row[5:3], px[7:3]}];
        attr  = vram_m[ATTR_BASE + {3'b000, row[7:3], px[7:3]}];
        pix   = bits[~px[2:0]];             // MSB is leftmost
        ink   = (attr[7] && phase) ? attr[5:3] : attr[2:0];
        paper = (attr[7] && phase) ? attr[2:0] : attr[5:3];
        return palette_rgb({attr[6], pix ? ink : paper});
    endfunction

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB master
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apb_access(input logic [13:0] addr, input logic wr, input byte_t wdata,
                              output byte_t rdata, output logic err, output int waits);
        @(posedge clk_pix);
        #2;
        paddr   = addr;                     // Setup phase
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk_pix);
        #2;
        penable = 1'b1;                     // Access phase
        waits   = 0;
        @(negedge clk_pix);
        while (!pready) begin
            waits++;
            @(negedge clk_pix);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_pix);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [13:0] addr, input byte_t data, input logic exp_err);
        byte_t rd;
        logic  err;
        int    waits;
        apb_access(addr, 1'b1, data, rd, err, waits);
        check("write_waits", 32'd0, 32'(waits));
        check("pslverr", 32'(exp_err), 32'(err));
    endtask

    task automatic apb_read(input logic [13:0] addr, input logic exp_err, output byte_t data);
        logic err;
        int   waits;
        apb_access(addr, 1'b0, 8'h00, data, err, waits);
        check("read_waits", 32'd1, 32'(waits));
        check("pslverr", 32'(exp_err), 32'(err));
    endtask

    // Returns on the first sample of the given frame
    task automatic wait_frame(input logic [4:0] f);
        while (!(m_frame == f && m_hc == 10'd0 && m_vc == 10'd0)) @(negedge clk_pix);
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        vram_addr_t  a;
        vram_addr_t  addr_list [0:63];
        logic [13:0] bad_addr;
        byte_t       d;
        byte_t       rd;
        logic [7:0]  flash_y;
        vcount_t     flash_vc;
        hcount_t     xo;
        rgb_t        act;
        int          swaps;

        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (5) @(posedge clk_pix);
        #2;
        rst_n = 1'b1;

        // Random RAM writes, then read back
        for (int i = 0; i < 64; i++) begin
            do a = 13'($random(seed)); while (a >= VRAM_BYTES);
            d = 8'($random(seed));
            apb_write({1'b0, a}, d, 1'b0);
            vram_m[a]    = d;
            addr_list[i] = a;
        end
        for (int i = 0; i < 64; i++) begin
            apb_read({1'b0, addr_list[i]}, 1'b0, rd);
            check("prdata", 32'(vram_m[addr_list[i]]), 32'(rd));
        end
        repeat (4) begin                        // Border keeps bits 2:0 only
            d = 8'($random(seed));
            apb_write(BORDER_ADDR, d, 1'b0);
            apb_read(BORDER_ADDR, 1'b0, rd);
            check("border", {29'd0, d[2:0]}, 32'(rd));
        end
        for (int i = 0; i < int'(VRAM_BYTES); i++) begin   // Whole screen for the picture
            d = 8'($random(seed));
            apb_write(14'(i), d, 1'b0);
            vram_m[13'(i)] = d;
        end
        d = 8'($random(seed));
        apb_write(BORDER_ADDR, d, 1'b0);
        border_m = d[2:0];
        end_test("APB access");

        // Unmapped addresses answer with an error and leave RAM alone
        repeat (16) begin
            do bad_addr = 14'($random(seed));
            while (bad_addr < {1'b0, VRAM_BYTES} || bad_addr == BORDER_ADDR);
            apb_write(bad_addr, 8'($random(seed)), 1'b1);
            apb_read(bad_addr, 1'b1, rd);
            if (bad_addr[12:0] < VRAM_BYTES) begin     // Low bits alias a RAM byte
                apb_read({1'b0, bad_addr[12:0]}, 1'b0, rd);
                check("prdata", 32'(vram_m[bad_addr[12:0]]), 32'(rd));
            end
        end
        apb_read(BORDER_ADDR, 1'b0, rd);
        check("border", {29'd0, border_m}, 32'(rd));
        end_test("Error response");

        // Every pixel of frame 1 with one screen row kept for the flash test
        do flash_y = 8'($random(seed)); while (flash_y >= 8'd192);
        flash_vc = V_SCR_START + {1'b0, flash_y, 1'b0};
        wait_frame(5'd1);
        repeat (FRAME_CYCLES) begin
            act = {vga_r, vga_g, vga_b};
            check("rgb", 32'(model_pixel(m_hc, m_vc, m_frame[4])), 32'(act));
            xo = m_hc - H_SCR_START;
            if (m_vc == flash_vc && m_hc >= H_SCR_START && m_hc < H_SCR_END)
                row1[xo[8:0]] = act;
            @(negedge clk_pix);
        end
        end_test("Picture");

        // Sync and interrupt over frames 2 and 3
        wait_frame(5'd2);
        repeat (2 * FRAME_CYCLES) begin
            check("hsync", 32'(m_hc >= H_SYNC), 32'(hsync));
            check("vsync", 32'(m_vc >= V_SYNC), 32'(vsync));
            check("irq_n", 32'(!(m_vc == IRQ_LINE && m_hc < IRQ_WIDTH)), 32'(irq_n));
            @(negedge clk_pix);
        end
        end_test("Sync and interrupt");

        // Same row in frame 17 with the flash phase high
        wait_frame(5'd17);
        while (!(m_vc == flash_vc && m_hc == H_SCR_START)) @(negedge clk_pix);
        swaps = 0;
        repeat (512) begin
            xo  = m_hc - H_SCR_START;
            act = {vga_r, vga_g, vga_b};
            check("rgb_frame17", 32'(model_pixel(m_hc, m_vc, 1'b1)), 32'(act));
            if (act != row1[xo[8:0]])
                swaps++;                        // Ink and paper traded places
            @(negedge clk_pix);
        end
        if (swaps == 0) begin
            errors++;
            $display("Flash made no visible change on the sampled row");
        end
        end_test("Flash");

        $display("Summary: %0d tests ok, %0d tests with errors, %0d check errors",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* ula_video.f */
ula_pkg.sv
raster_if.sv
vga_timing.sv
screen_fetch.sv
pixel_render.sv
vram.sv
apb_ula_port.sv
ula_video_top.sv
ula_video_assertions.sv
tb_ula_video.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ula_video \
    -f ula_video.f -o sim_ula_video
./obj_dir/sim_ula_video | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
